/* include/cpu_defs.svh */
// cpu_defs: widths, depths and sizes of the byte-serial core
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// ram address and byte width
`define ADDR_W 16
`define DATA_W 8

// register file size
`define REG_NUM 64

// ram bytes, addresses wrap modulo this
`define RAM_DEPTH 4096

// instruction length, also the jump step
`define INSTR_BYTES 4

`endif

/* hdl/cpu_bus_pkg.sv */
// cpu_bus_pkg: address, byte and register index types of the core buses
`include "cpu_defs.svh"

package cpu_bus_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;

  typedef logic [`DATA_W-1:0] data_t;

  // index sums wrap over the register file
  typedef logic [$clog2(`REG_NUM)-1:0] reg_idx_t;

endpackage

/* hdl/cpu_isa_pkg.sv */
// cpu_isa_pkg: opcodes, alu operations and the command passed to the execute units
`include "cpu_defs.svh"

package cpu_isa_pkg;

  typedef enum logic [`DATA_W-1:0] {
    LOADFROMRAM = 1,
    JUMPMINUS   = 2,
    WRITETORAM  = 3,
    ADD8        = 4,
    JUMPPLUS    = 5,
    ADDNUM8     = 6,
    READFROMRAM = 7,
    SAVETORAM   = 8,
    SET8        = 9
  } opcode_e;

  typedef enum logic [1:0] {ADD, ADDNUM, SETNUM} alu_op_e;

  // destination is src2_start for ADD, src_start otherwise
  typedef struct packed {
    alu_op_e               alu_op;
    cpu_bus_pkg::reg_idx_t src_start;
    cpu_bus_pkg::reg_idx_t src2_start;
    cpu_bus_pkg::data_t    value;
    cpu_bus_pkg::data_t    length;
    cpu_bus_pkg::addr_t    ram_addr;
  } exec_cmd_t;

endpackage

/* hdl/mem_port_if.sv */
// mem_port_if: single byte request/ready port between a client and a memory server
`timescale 1ns/100ps

interface mem_port_if;

  logic               req;
  logic               we;
  cpu_bus_pkg::addr_t addr;
  cpu_bus_pkg::data_t wdata;
  logic               ready;
  cpu_bus_pkg::data_t rdata;

  // request fields stay steady until ready
  modport client (output req, we, addr, wdata, input ready, rdata);

  modport server (input req, we, addr, wdata, output ready, rdata);

endinterface

/* hdl/fetch_decode.sv */
// fetch_decode: program counter, instruction fetch, decode and execute unit sequencing
`timescale 1ns/100ps
`include "cpu_defs.svh"

module fetch_decode (
  input  logic                   ram_clk,
  input  logic                   stage3_read,
  input  logic                   run,
  mem_port_if.client             ram,
  mem_port_if.client             regs,
  output cpu_bus_pkg::addr_t     pc,
  output logic                   instr_done,
  output logic                   load_start,
  output logic                   alu_start,
  output logic                   store_start,
  output cpu_isa_pkg::exec_cmd_t cmd,
  input  logic                   load_done,
  input  logic                   alu_done,
  input  logic                   store_done
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_FETCH, ST_DECODE, ST_INDIRECT, ST_EXEC, ST_FINISH
  } state_e;

  state_e                 state;
  logic [1:0]             byte_idx;
  logic                   ram_req;
  logic                   reg_req;
  cpu_bus_pkg::data_t     ib [4];
  cpu_isa_pkg::opcode_e   opcode;
  cpu_bus_pkg::addr_t     jump_step;

  assign opcode    = cpu_isa_pkg::opcode_e'(ib[0]);
  assign jump_step = cpu_bus_pkg::addr_t'(`INSTR_BYTES) * cpu_bus_pkg::addr_t'(ib[1]);

  assign ram.req   = ram_req;
  assign ram.we    = 1'b0;
  assign ram.addr  = pc + cpu_bus_pkg::addr_t'(byte_idx);
  assign ram.wdata = '0;

  // indirect address register is byte 3
  assign regs.req   = reg_req;
  assign regs.we    = 1'b0;
  assign regs.addr  = cpu_bus_pkg::addr_t'(ib[3]);
  assign regs.wdata = '0;

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      state       <= ST_IDLE;
      pc          <= '0;
      byte_idx    <= '0;
      ram_req     <= 1'b0;
      reg_req     <= 1'b0;
      instr_done  <= 1'b0;
      load_start  <= 1'b0;
      alu_start   <= 1'b0;
      store_start <= 1'b0;
    end else begin
      instr_done  <= 1'b0;
      load_start  <= 1'b0;
      alu_start   <= 1'b0;
      store_start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (run) begin
            byte_idx <= '0;
            ram_req  <= 1'b1;
            state    <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          if (ram_req && ram.ready) begin
            ram_req  <= 1'b0;
            byte_idx <= byte_idx + 2'd1;
            // jumps need only bytes 0 and 1
            if (byte_idx == 2'd1 && (opcode == cpu_isa_pkg::JUMPPLUS ||
                                     opcode == cpu_isa_pkg::JUMPMINUS)) begin
              state <= ST_FINISH;
            end else if (byte_idx == 2'd3) begin
              state <= ST_DECODE;
            end
          end else if (!ram_req) begin
            ram_req <= 1'b1;
          end
        end
        ST_DECODE: begin
          case (opcode)
            cpu_isa_pkg::LOADFROMRAM: begin
              load_start <= 1'b1;
              state      <= ST_EXEC;
            end
            cpu_isa_pkg::WRITETORAM: begin
              store_start <= 1'b1;
              state       <= ST_EXEC;
            end
            cpu_isa_pkg::READFROMRAM, cpu_isa_pkg::SAVETORAM: begin
              reg_req <= 1'b1;
              state   <= ST_INDIRECT;
            end
            cpu_isa_pkg::ADD8, cpu_isa_pkg::ADDNUM8, cpu_isa_pkg::SET8: begin
              alu_start <= 1'b1;
              state     <= ST_EXEC;
            end
            default: state <= ST_FINISH;
          endcase
        end
        ST_INDIRECT: begin
          if (regs.ready) begin
            reg_req     <= 1'b0;
            load_start  <= (opcode == cpu_isa_pkg::READFROMRAM);
            store_start <= (opcode == cpu_isa_pkg::SAVETORAM);
            state       <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (load_done || alu_done || store_done) begin
            state <= ST_FINISH;
          end
        end
        default: begin
          instr_done <= 1'b1;
          state      <= ST_IDLE;
          case (opcode)
            cpu_isa_pkg::JUMPPLUS:  pc <= pc + jump_step;
            cpu_isa_pkg::JUMPMINUS: pc <= pc - jump_step;
            default:                pc <= pc + cpu_bus_pkg::addr_t'(`INSTR_BYTES);
          endcase
        end
      endcase
    end
  end

  // instruction bytes and the unit command
  always_ff @(posedge ram_clk) begin
    if (state == ST_FETCH && ram_req && ram.ready) begin
      ib[byte_idx] <= ram.rdata;
    end
    if (state == ST_INDIRECT && regs.ready) begin
      cmd.ram_addr <= cpu_bus_pkg::addr_t'(regs.rdata);
    end
    if (state == ST_DECODE) begin
      cmd.src_start <= cpu_bus_pkg::reg_idx_t'(ib[1]);
      cmd.ram_addr  <= cpu_bus_pkg::addr_t'(ib[3]);
      case (opcode)
        cpu_isa_pkg::ADD8: begin
          cmd.alu_op     <= cpu_isa_pkg::ADD;
          cmd.src2_start <= cpu_bus_pkg::reg_idx_t'(ib[2]);
          cmd.length     <= ib[3];
        end
        cpu_isa_pkg::ADDNUM8: begin
          cmd.alu_op <= cpu_isa_pkg::ADDNUM;
          cmd.value  <= ib[2];
          cmd.length <= ib[3];
        end
        cpu_isa_pkg::SET8: begin
          cmd.alu_op <= cpu_isa_pkg::SETNUM;
          cmd.value  <= ib[3];
          cmd.length <= ib[2];
        end
        default: cmd.length <= ib[2];
      endcase
    end
  end

  a_one_start: assert property (@(posedge ram_clk) disable iff (stage3_read)
    $onehot0({load_start, alu_start, store_start}));

  // pc only moves at an instruction boundary
  a_pc_at_finish: assert property (@(posedge ram_clk) disable iff (stage3_read)
    !$stable(pc) |-> $past(state) == ST_FINISH);

endmodule

/* hdl/ram_load.sv */
// ram_load: copies a block of RAM bytes into consecutive registers
`timescale 1ns/100ps

module ram_load (
  input  logic                   ram_clk,
  input  logic                   stage3_read,
  input  logic                   start,
  input  cpu_isa_pkg::exec_cmd_t cmd,
  output logic                   done,
  mem_port_if.client             ram,
  mem_port_if.client             regs
);

  typedef enum logic [1:0] {ST_IDLE, ST_RAM_RD, ST_REG_WR} state_e;

  state_e             state;
  cpu_bus_pkg::data_t cnt;
  cpu_bus_pkg::data_t byte_q;
  logic               ram_req;
  logic               reg_req;

  assign ram.req   = ram_req;
  assign ram.we    = 1'b0;
  assign ram.addr  = cmd.ram_addr + cpu_bus_pkg::addr_t'(cnt);
  assign ram.wdata = '0;

  assign regs.req   = reg_req;
  assign regs.we    = 1'b1;
  assign regs.addr  = cpu_bus_pkg::addr_t'(cpu_bus_pkg::reg_idx_t'(cmd.src_start + cnt));
  assign regs.wdata = byte_q;

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      state   <= ST_IDLE;
      cnt     <= '0;
      ram_req <= 1'b0;
      reg_req <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            cnt <= '0;
            if (cmd.length == '0) begin
              done <= 1'b1;
            end else begin
              ram_req <= 1'b1;
              state   <= ST_RAM_RD;
            end
          end
        end
        ST_RAM_RD: begin
          if (ram.ready) begin
            ram_req <= 1'b0;
            reg_req <= 1'b1;
            state   <= ST_REG_WR;
          end
        end
        default: begin
          if (regs.ready) begin
            reg_req <= 1'b0;
            cnt     <= cnt + 1'b1;
            if (cnt + 1'b1 == cmd.length) begin
              done  <= 1'b1;
              state <= ST_IDLE;
            end else begin
              ram_req <= 1'b1;
              state   <= ST_RAM_RD;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge ram_clk) begin
    if (state == ST_RAM_RD && ram.ready) begin
      byte_q <= ram.rdata;
    end
  end

endmodule

/* hdl/alu_exec.sv */
// alu_exec: byte-serial add, add-immediate and set over blocks of registers
`timescale 1ns/100ps

module alu_exec (
  input  logic                   ram_clk,
  input  logic                   stage3_read,
  input  logic                   start,
  input  cpu_isa_pkg::exec_cmd_t cmd,
  output logic                   done,
  mem_port_if.client             regs
);

  typedef enum logic [1:0] {ST_IDLE, ST_RD_A, ST_RD_B, ST_WR} state_e;

  state_e                state;
  cpu_bus_pkg::data_t    cnt;
  cpu_bus_pkg::data_t    acc;
  cpu_bus_pkg::reg_idx_t idx;
  logic                  req_q;

  // ADD writes back into the second block
  always_comb begin
    if (state == ST_RD_B || (state == ST_WR && cmd.alu_op == cpu_isa_pkg::ADD)) begin
      idx = cpu_bus_pkg::reg_idx_t'(cmd.src2_start + cnt);
    end else begin
      idx = cpu_bus_pkg::reg_idx_t'(cmd.src_start + cnt);
    end
  end

  assign regs.req   = req_q;
  assign regs.we    = (state == ST_WR);
  assign regs.addr  = cpu_bus_pkg::addr_t'(idx);
  assign regs.wdata = acc;

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      state <= ST_IDLE;
      cnt   <= '0;
      req_q <= 1'b0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (state == ST_IDLE) begin
        if (start) begin
          cnt <= '0;
          if (cmd.length == '0) begin
            done <= 1'b1;
          end else begin
            state <= (cmd.alu_op == cpu_isa_pkg::SETNUM) ? ST_WR : ST_RD_A;
          end
        end
      end else if (req_q && regs.ready) begin
        // one idle cycle between transfers on the port
        req_q <= 1'b0;
        case (state)
          ST_RD_A: state <= (cmd.alu_op == cpu_isa_pkg::ADD) ? ST_RD_B : ST_WR;
          ST_RD_B: state <= ST_WR;
          default: begin
            cnt <= cnt + 1'b1;
            if (cnt + 1'b1 == cmd.length) begin
              done  <= 1'b1;
              state <= ST_IDLE;
            end else begin
              state <= (cmd.alu_op == cpu_isa_pkg::SETNUM) ? ST_WR : ST_RD_A;
            end
          end
        endcase
      end else if (!req_q) begin
        req_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge ram_clk) begin
    if (state == ST_IDLE) begin
      acc <= cmd.value;
    end else if (req_q && regs.ready && state == ST_RD_A) begin
      acc <= (cmd.alu_op == cpu_isa_pkg::ADDNUM) ? regs.rdata + cmd.value : regs.rdata;
    end else if (req_q && regs.ready && state == ST_RD_B) begin
      acc <= acc + regs.rdata;
    end
  end

  // a pending read is not turned into a write
  a_no_wr_on_rd: assert property (@(posedge ram_clk) disable iff (stage3_read)
    regs.req && !regs.we && !regs.ready |=> regs.req && !regs.we);

endmodule

/* hdl/ram_store.sv */
// ram_store: copies a block of registers into consecutive RAM bytes
`timescale 1ns/100ps

module ram_store (
  input  logic                   ram_clk,
  input  logic                   stage3_read,
  input  logic                   start,
  input  cpu_isa_pkg::exec_cmd_t cmd,
  output logic                   done,
  mem_port_if.client             regs,
  mem_port_if.client             ram
);

  typedef enum logic [1:0] {ST_IDLE, ST_REG_RD, ST_RAM_WR} state_e;

  state_e             state;
  cpu_bus_pkg::data_t cnt;
  cpu_bus_pkg::data_t byte_q;
  logic               reg_req;
  logic               ram_req;

  assign regs.req   = reg_req;
  assign regs.we    = 1'b0;
  assign regs.addr  = cpu_bus_pkg::addr_t'(cpu_bus_pkg::reg_idx_t'(cmd.src_start + cnt));
  assign regs.wdata = '0;

  assign ram.req   = ram_req;
  assign ram.we    = 1'b1;
  assign ram.addr  = cmd.ram_addr + cpu_bus_pkg::addr_t'(cnt);
  assign ram.wdata = byte_q;

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      state   <= ST_IDLE;
      cnt     <= '0;
      reg_req <= 1'b0;
      ram_req <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            cnt <= '0;
            if (cmd.length == '0) begin
              done <= 1'b1;
            end else begin
              reg_req <= 1'b1;
              state   <= ST_REG_RD;
            end
          end
        end
        ST_REG_RD: begin
          if (regs.ready) begin
            reg_req <= 1'b0;
            ram_req <= 1'b1;
            state   <= ST_RAM_WR;
          end
        end
        default: begin
          if (ram.ready) begin
            ram_req <= 1'b0;
            cnt     <= cnt + 1'b1;
            if (cnt + 1'b1 == cmd.length) begin
              done  <= 1'b1;
              state <= ST_IDLE;
            end else begin
              reg_req <= 1'b1;
              state   <= ST_REG_RD;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge ram_clk) begin
    if (state == ST_REG_RD && regs.ready) begin
      byte_q <= regs.rdata;
    end
  end

endmodule

/* hdl/ram_arbiter.sv */
// ram_arbiter: fixed-priority access of fetch, load, store and host to the byte RAM
`timescale 1ns/100ps
`include "cpu_defs.svh"

module ram_arbiter (
  input  logic               ram_clk,
  input  logic               stage3_read,
  mem_port_if.server         fetch,
  mem_port_if.server         load,
  mem_port_if.server         store,
  input  logic               host_req,
  input  logic               host_we,
  input  cpu_bus_pkg::addr_t host_addr,
  input  cpu_bus_pkg::data_t host_wdata,
  output logic               host_ready,
  output cpu_bus_pkg::data_t host_rdata
);

  localparam int IDX_W = $clog2(`RAM_DEPTH);

  typedef enum logic {ST_IDLE, ST_READ} state_e;

  state_e             state;
  logic [3:0]         req_v;
  logic [3:0]         we_v;
  logic [3:0]         ready_q;
  cpu_bus_pkg::addr_t addr_v [4];
  cpu_bus_pkg::data_t wdata_v [4];
  cpu_bus_pkg::data_t mem [`RAM_DEPTH];
  cpu_bus_pkg::data_t rdata_q;
  logic [1:0]         sel;
  logic [1:0]         sel_q;
  logic               hit;
  logic [IDX_W-1:0]   idx;

  // index 0 has the highest priority
  assign req_v   = {host_req, store.req, load.req, fetch.req};
  assign we_v    = {host_we, store.we, load.we, fetch.we};
  assign addr_v  = '{fetch.addr, load.addr, store.addr, host_addr};
  assign wdata_v = '{fetch.wdata, load.wdata, store.wdata, host_wdata};
  assign idx     = addr_v[sel][IDX_W-1:0];

  // a port whose ready is up still holds req this cycle
  always_comb begin
    hit = 1'b0;
    sel = '0;
    for (int i = 3; i >= 0; i--) begin
      if (state == ST_IDLE && req_v[i] && !ready_q[i]) begin
        hit = 1'b1;
        sel = 2'(i);
      end
    end
  end

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      state   <= ST_IDLE;
      ready_q <= '0;
      sel_q   <= '0;
    end else begin
      ready_q <= '0;
      if (state == ST_READ) begin
        ready_q[sel_q] <= 1'b1;
        state          <= ST_IDLE;
      end else if (hit) begin
        sel_q <= sel;
        if (we_v[sel]) begin
          ready_q[sel] <= 1'b1;
        end else begin
          state <= ST_READ;
        end
      end
    end
  end

  always_ff @(posedge ram_clk) begin
    if (hit && we_v[sel]) begin
      mem[idx] <= wdata_v[sel];
    end else if (hit) begin
      rdata_q <= mem[idx];
    end
  end

  assign fetch.ready = ready_q[0];
  assign load.ready  = ready_q[1];
  assign store.ready = ready_q[2];
  assign host_ready  = ready_q[3];
  assign fetch.rdata = rdata_q;
  assign load.rdata  = rdata_q;
  assign store.rdata = rdata_q;
  assign host_rdata  = rdata_q;

  a_ready_onehot: assert property (@(posedge ram_clk) disable iff (stage3_read)
    $onehot0({host_ready, store.ready, load.ready, fetch.ready}));

endmodule

/* hdl/register_file.sv */
// register_file: 64-byte register array serving four ports in fixed priority
`timescale 1ns/100ps
`include "cpu_defs.svh"

module register_file (
  input  logic       ram_clk,
  input  logic       stage3_read,
  mem_port_if.server fetch,
  mem_port_if.server load,
  mem_port_if.server alu,
  mem_port_if.server store
);

  logic [3:0]            req_v;
  logic [3:0]            we_v;
  logic [3:0]            ready_q;
  cpu_bus_pkg::addr_t    addr_v [4];
  cpu_bus_pkg::data_t    wdata_v [4];
  cpu_bus_pkg::data_t    regs_q [`REG_NUM];
  cpu_bus_pkg::data_t    rdata_q;
  cpu_bus_pkg::reg_idx_t idx;
  logic [1:0]            sel;
  logic                  hit;

  assign req_v   = {store.req, alu.req, load.req, fetch.req};
  assign we_v    = {store.we, alu.we, load.we, fetch.we};
  assign addr_v  = '{fetch.addr, load.addr, alu.addr, store.addr};
  assign wdata_v = '{fetch.wdata, load.wdata, alu.wdata, store.wdata};
  assign idx     = cpu_bus_pkg::reg_idx_t'(addr_v[sel]);

  // one transfer per cycle, lowest index wins
  always_comb begin
    hit = 1'b0;
    sel = '0;
    for (int i = 3; i >= 0; i--) begin
      if (req_v[i] && !ready_q[i]) begin
        hit = 1'b1;
        sel = 2'(i);
      end
    end
  end

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      ready_q <= '0;
      for (int i = 0; i < `REG_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      ready_q <= '0;
      if (hit) begin
        ready_q[sel] <= 1'b1;
        if (we_v[sel]) begin
          regs_q[idx] <= wdata_v[sel];
        end
      end
    end
  end

  always_ff @(posedge ram_clk) begin
    if (hit) begin
      rdata_q <= regs_q[idx];
    end
  end

  assign fetch.ready = ready_q[0];
  assign load.ready  = ready_q[1];
  assign alu.ready   = ready_q[2];
  assign store.ready = ready_q[3];
  assign fetch.rdata = rdata_q;
  assign load.rdata  = rdata_q;
  assign alu.rdata   = rdata_q;
  assign store.rdata = rdata_q;

  // fetch and store only ever read registers
  a_read_only: assert property (@(posedge ram_clk) disable iff (stage3_read)
    !(fetch.req && fetch.we) && !(store.req && store.we));

endmodule

/* hdl/cpu_top.sv */
// cpu_top: byte-serial core with execute units, shared RAM, register file and host port
`timescale 1ns/100ps

module cpu_top (
  input  logic               ram_clk,
  input  logic               stage3_read,
  input  logic               run,
  input  logic               host_req,
  input  logic               host_we,
  input  cpu_bus_pkg::addr_t host_addr,
  input  cpu_bus_pkg::data_t host_wdata,
  output logic               host_ready,
  output cpu_bus_pkg::data_t host_rdata,
  output cpu_bus_pkg::addr_t pc,
  output logic               instr_done
);

  logic                   load_start;
  logic                   alu_start;
  logic                   store_start;
  logic                   load_done;
  logic                   alu_done;
  logic                   store_done;
  cpu_isa_pkg::exec_cmd_t cmd;

  // ram ports
  mem_port_if ram_fetch ();
  mem_port_if ram_load ();
  mem_port_if ram_store ();

  // register ports
  mem_port_if reg_fetch ();
  mem_port_if reg_load ();
  mem_port_if reg_alu ();
  mem_port_if reg_store ();

  fetch_decode i_fetch_decode (
    .ram_clk     (ram_clk),
    .stage3_read (stage3_read),
    .run         (run),
    .ram         (ram_fetch),
    .regs        (reg_fetch),
    .pc          (pc),
    .instr_done  (instr_done),
    .load_start  (load_start),
    .alu_start   (alu_start),
    .store_start (store_start),
    .cmd         (cmd),
    .load_done   (load_done),
    .alu_done    (alu_done),
    .store_done  (store_done)
  );

  ram_load i_ram_load (
    .ram_clk     (ram_clk),
    .stage3_read (stage3_read),
    .start       (load_start),
    .cmd         (cmd),
    .done        (load_done),
    .ram         (ram_load),
    .regs        (reg_load)
  );

  alu_exec i_alu_exec (
    .ram_clk     (ram_clk),
    .stage3_read (stage3_read),
    .start       (alu_start),
    .cmd         (cmd),
    .done        (alu_done),
    .regs        (reg_alu)
  );

  ram_store i_ram_store (
    .ram_clk     (ram_clk),
    .stage3_read (stage3_read),
    .start       (store_start),
    .cmd         (cmd),
    .done        (store_done),
    .regs        (reg_store),
    .ram         (ram_store)
  );

  ram_arbiter i_ram_arbiter (
    .ram_clk     (ram_clk),
    .stage3_read (stage3_read),
    .fetch       (ram_fetch),
    .load        (ram_load),
    .store       (ram_store),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_ready  (host_ready),
    .host_rdata  (host_rdata)
  );

  register_file i_register_file (
    .ram_clk     (ram_clk),
    .stage3_read (stage3_read),
    .fetch       (reg_fetch),
    .load        (reg_load),
    .alu         (reg_alu),
    .store       (reg_store)
  );

endmodule

/* tests/tb_cpu.sv */
// tb_cpu: directed tests of the byte-serial core through its host port and run control
`timescale 1ns/100ps
`include "cpu_defs.svh"

module tb_cpu;

  localparam int CLK_HALF        = 20;
  localparam int RESET_CYCLES    = 10;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST;
  localparam int QUIET_CYCLES    = 100;

  logic               ram_clk;
  logic               stage3_read;
  logic               run;
  logic               host_req;
  logic               host_we;
  cpu_bus_pkg::addr_t host_addr;
  cpu_bus_pkg::data_t host_wdata;
  logic               host_ready;
  cpu_bus_pkg::data_t host_rdata;
  cpu_bus_pkg::addr_t pc;
  logic               instr_done;

  // expected pc and the next free program address
  cpu_bus_pkg::addr_t exp_pc;
  cpu_bus_pkg::addr_t prog_ptr;

  cpu_top i_dut (
    .ram_clk     (ram_clk),
    .stage3_read (stage3_read),
    .run         (run),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_ready  (host_ready),
    .host_rdata  (host_rdata),
    .pc          (pc),
    .instr_done  (instr_done)
  );

  initial begin
    ram_clk = 1'b0;
    forever #CLK_HALF ram_clk = ~ram_clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ram_clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      $display("Error at time %0t: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // inputs change and outputs are sampled 2 ns after the edge
  task automatic step_cycle;
    @(posedge ram_clk);
    #2;
  endtask

  task automatic host_write(input cpu_bus_pkg::addr_t addr, input cpu_bus_pkg::data_t data);
    host_req   = 1'b1;
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    step_cycle();
    while (!host_ready) begin
      step_cycle();
    end
    host_req = 1'b0;
    host_we  = 1'b0;
    step_cycle();
  endtask

  task automatic host_read(input cpu_bus_pkg::addr_t addr, output cpu_bus_pkg::data_t data);
    host_req  = 1'b1;
    host_we   = 1'b0;
    host_addr = addr;
    step_cycle();
    while (!host_ready) begin
      step_cycle();
    end
    data     = host_rdata;
    host_req = 1'b0;
    step_cycle();
  endtask

  task automatic check_ram(input cpu_bus_pkg::addr_t addr, input cpu_bus_pkg::data_t exp);
    cpu_bus_pkg::data_t rd;
    host_read(addr, rd);
    check_eq($sformatf("ram[0x%0h]", addr), 16'(exp), 16'(rd));
  endtask

  task automatic write_instr(input cpu_bus_pkg::addr_t addr, input cpu_isa_pkg::opcode_e op,
                             input cpu_bus_pkg::data_t b1, input cpu_bus_pkg::data_t b2,
                             input cpu_bus_pkg::data_t b3);
    host_write(addr, cpu_bus_pkg::data_t'(op));
    host_write(addr + 16'd1, b1);
    host_write(addr + 16'd2, b2);
    host_write(addr + 16'd3, b3);
  endtask

  task automatic place_instr(input cpu_isa_pkg::opcode_e op, input cpu_bus_pkg::data_t b1,
                             input cpu_bus_pkg::data_t b2, input cpu_bus_pkg::data_t b3);
    write_instr(prog_ptr, op, b1, b2, b3);
    prog_ptr = prog_ptr + 16'(`INSTR_BYTES);
  endtask

  task automatic run_instrs(input int n);
    int count;
    count = 0;
    run   = 1'b1;
    while (count < n) begin
      step_cycle();
      if (instr_done) begin
        count++;
      end
    end
    run = 1'b0;
    // long enough for one more instruction to finish if the core kept going
    repeat (QUIET_CYCLES) begin
      step_cycle();
      check_eq("instr_done", 16'd0, 16'(instr_done));
    end
  endtask

  // straight-line code moves pc one instruction at a time
  task automatic run_straight(input int n);
    run_instrs(n);
    exp_pc = exp_pc + 16'(n * `INSTR_BYTES);
    check_eq("pc", exp_pc, pc);
  endtask

  task automatic test_host_rw;
    cpu_bus_pkg::addr_t addrs [4];
    cpu_bus_pkg::data_t vals [4];
    cpu_bus_pkg::data_t wrap_val;
    addrs = '{16'h0300, 16'h0421, 16'h0fff, 16'h0abc};
    for (int i = 0; i < 4; i++) begin
      vals[i] = cpu_bus_pkg::data_t'($urandom);
      host_write(addrs[i], vals[i]);
    end
    for (int i = 0; i < 4; i++) begin
      check_ram(addrs[i], vals[i]);
    end
    // addresses beyond the array fold onto the low bits
    wrap_val = cpu_bus_pkg::data_t'($urandom);
    host_write(16'(`RAM_DEPTH) + 16'h0123, wrap_val);
    check_ram(16'h0123, wrap_val);
    wrap_val = cpu_bus_pkg::data_t'($urandom);
    host_write(16'h0456, wrap_val);
    check_ram(16'(2 * `RAM_DEPTH) + 16'h0456, wrap_val);
  endtask

  // runs first so that pc is still at address 0
  task automatic test_jumps;
    host_write(16'h00f0, 8'h5a);
    write_instr(16'h0000, cpu_isa_pkg::JUMPPLUS, 8'd2, 8'd0, 8'd0);
    write_instr(16'h0004, cpu_isa_pkg::WRITETORAM, 8'd0, 8'd1, 8'hf0);
    write_instr(16'h0008, cpu_isa_pkg::JUMPMINUS, 8'd1, 8'd0, 8'd0);
    run_instrs(1);
    exp_pc = exp_pc + 16'(`INSTR_BYTES * 2);
    check_eq("pc", exp_pc, pc);
    check_ram(16'h00f0, 8'h5a);
    run_instrs(1);
    exp_pc = exp_pc - 16'(`INSTR_BYTES * 1);
    check_eq("pc", exp_pc, pc);
    prog_ptr = exp_pc;
  endtask

  task automatic test_copy;
    cpu_bus_pkg::data_t src [5];
    for (int i = 0; i < 5; i++) begin
      src[i] = cpu_bus_pkg::data_t'($urandom);
      host_write(16'h0080 + 16'(i), src[i]);
    end
    place_instr(cpu_isa_pkg::LOADFROMRAM, 8'd10, 8'd5, 8'h80);
    place_instr(cpu_isa_pkg::WRITETORAM, 8'd10, 8'd5, 8'h90);
    run_straight(2);
    for (int i = 0; i < 5; i++) begin
      check_ram(16'h0090 + 16'(i), src[i]);
    end
  endtask

  task automatic test_alu;
    cpu_bus_pkg::data_t v;
    cpu_bus_pkg::data_t k;
    cpu_bus_pkg::data_t set_add;
    cpu_bus_pkg::data_t opnd [4];
    cpu_bus_pkg::data_t sum [4];
    v = cpu_bus_pkg::data_t'($urandom);
    k = cpu_bus_pkg::data_t'($urandom);
    for (int i = 0; i < 4; i++) begin
      opnd[i] = cpu_bus_pkg::data_t'($urandom);
      host_write(16'h00a0 + 16'(i), opnd[i]);
    end
    place_instr(cpu_isa_pkg::SET8, 8'd20, 8'd4, v);
    place_instr(cpu_isa_pkg::ADDNUM8, 8'd20, k, 8'd4);
    place_instr(cpu_isa_pkg::LOADFROMRAM, 8'd24, 8'd4, 8'ha0);
    place_instr(cpu_isa_pkg::ADD8, 8'd20, 8'd24, 8'd4);
    place_instr(cpu_isa_pkg::WRITETORAM, 8'd20, 8'd4, 8'hb0);
    place_instr(cpu_isa_pkg::WRITETORAM, 8'd24, 8'd4, 8'hb4);
    run_straight(6);
    // byte sums wrap at 256
    set_add = v + k;
    for (int i = 0; i < 4; i++) begin
      sum[i] = set_add + opnd[i];
      check_ram(16'h00b0 + 16'(i), set_add);
      check_ram(16'h00b4 + 16'(i), sum[i]);
    end
  endtask

  task automatic test_indirect;
    cpu_bus_pkg::data_t data [3];
    host_write(16'h00c0, 8'hd0);
    host_write(16'h00c1, 8'he0);
    for (int i = 0; i < 3; i++) begin
      data[i] = cpu_bus_pkg::data_t'($urandom);
      host_write(16'h00d0 + 16'(i), data[i]);
    end
    // r30 and r31 hold the source and destination pointers
    place_instr(cpu_isa_pkg::LOADFROMRAM, 8'd30, 8'd2, 8'hc0);
    place_instr(cpu_isa_pkg::READFROMRAM, 8'd40, 8'd3, 8'd30);
    place_instr(cpu_isa_pkg::SAVETORAM, 8'd40, 8'd3, 8'd31);
    run_straight(3);
    for (int i = 0; i < 3; i++) begin
      check_ram(16'h00e0 + 16'(i), data[i]);
    end
  endtask

  task automatic test_zero_and_stop;
    host_write(16'h00f8, 8'hc3);
    host_write(16'h00fa, 8'h77);
    place_instr(cpu_isa_pkg::LOADFROMRAM, 8'd50, 8'd0, 8'hf8);
    place_instr(cpu_isa_pkg::WRITETORAM, 8'd50, 8'd0, 8'hf8);
    // r50 is still zero unless the empty load wrote it
    place_instr(cpu_isa_pkg::WRITETORAM, 8'd50, 8'd1, 8'hfa);
    run_straight(3);
    check_ram(16'h00f8, 8'hc3);
    check_ram(16'h00fa, 8'h00);
    for (int i = 0; i < 4; i++) begin
      place_instr(cpu_isa_pkg::SET8, 8'(60 + i), 8'd1, 8'(i + 1));
    end
    run_straight(2);
    repeat (10) step_cycle();
    check_eq("pc", exp_pc, pc);
  endtask

  initial begin
    void'($urandom(32'hdda9e662));
    stage3_read = 1'b1;
    run         = 1'b0;
    host_req    = 1'b0;
    host_we     = 1'b0;
    host_addr   = '0;
    host_wdata  = '0;
    exp_pc      = '0;
    prog_ptr    = '0;
    repeat (RESET_CYCLES) @(posedge ram_clk);
    #2;
    stage3_read = 1'b0;
    step_cycle();
    check_eq("pc", 16'd0, pc);
    check_eq("instr_done", 16'd0, 16'(instr_done));
    check_eq("host_ready", 16'd0, 16'(host_ready));

    test_host_rw();
    test_jumps();
    test_copy();
    test_alu();
    test_indirect();
    test_zero_and_stop();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* build.f */
+incdir+include
hdl/cpu_bus_pkg.sv
hdl/cpu_isa_pkg.sv
hdl/mem_port_if.sv
hdl/fetch_decode.sv
hdl/ram_load.sv
hdl/alu_exec.sv
hdl/ram_store.sv
hdl/ram_arbiter.sv
hdl/register_file.sv
hdl/cpu_top.sv
tests/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_cpu
FILELIST  := build.f
PASS_MSG  := Simulation finished: PASS

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
